/* build.f */
usb_bus_pkg.sv
capture_pkg.sv
usb_reg_port.sv
capture_ctrl_regs.sv
capture_fifo.sv
status_leds.sv
capture_top.sv
tb_capture_top.sv

/* capture_ctrl_regs.sv */
`timescale 1ns/1ps

module capture_ctrl_regs
   import usb_bus_pkg::*, capture_pkg::*;
(
   input  logic                  clk_usb_buf,
   input  logic                  rst_n_i,
   input  logic [4:0]            reg_offset_i,
   input  logic [BYTECNT_W-1:0]  reg_bytecnt_i,
   input  logic [7:0]            reg_wdata_i,
   input  logic                  reg_write_i,
   input  logic                  reg_read_i,
   input  logic                  fifo_empty_i,
   input  logic                  fifo_full_i,
   input  logic                  overflow_i,
   input  logic [FIFO_CNT_W-1:0] fifo_count_i,
   output logic [7:0]            regs_rdata_o,
   output logic                  src_sel_o,
   output logic                  capture_en_o,
   output logic                  clear_errors_o
);

   logic [15:0] word_count;
   logic [7:0]  status_byte;
   logic [7:0]  rd_byte;

   assign word_count = 16'(fifo_count_i);

   always_comb begin
      status_byte                 = 8'h00;
      status_byte[STAT_EMPTY_BIT] = fifo_empty_i;
      status_byte[STAT_FULL_BIT]  = fifo_full_i;
      status_byte[STAT_OVF_BIT]   = overflow_i;
   end

   always_comb begin
      rd_byte = 8'h00;
      case (reg_offset_i)
         OFS_CTRL: begin
            rd_byte[CTRL_SRC_BIT] = src_sel_o;
            rd_byte[CTRL_EN_BIT]  = capture_en_o;
         end
         OFS_STATUS:    rd_byte = status_byte;
         OFS_WORDCOUNT: rd_byte = reg_bytecnt_i[0] ? word_count[15:8] : word_count[7:0];
         default:       rd_byte = 8'h00;   // clear register reads as zero
      endcase
   end

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         src_sel_o      <= SRC_TRACE;
         capture_en_o   <= 1'b0;
         clear_errors_o <= 1'b0;
      end else begin
         // single cycle pulse per write
         clear_errors_o <= reg_write_i && (reg_offset_i == OFS_CLEAR)
                           && reg_wdata_i[CLEAR_ERR_BIT];
         if (reg_write_i && (reg_offset_i == OFS_CTRL)) begin
            src_sel_o    <= reg_wdata_i[CTRL_SRC_BIT];
            capture_en_o <= reg_wdata_i[CTRL_EN_BIT];
         end
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (reg_read_i)
         regs_rdata_o <= rd_byte;
   end

endmodule

/* capture_fifo.sv */
`timescale 1ns/1ps

module capture_fifo
   import usb_bus_pkg::*, capture_pkg::*;
(
   input  logic                  clk_usb_buf,
   input  logic                  rst_n_i,
   input  logic                  trace_valid_i,
   input  logic [SAMPLE_W-1:0]   trace_data_i,
   input  logic                  la_valid_i,
   input  logic [SAMPLE_W-1:0]   la_data_i,
   input  logic                  src_sel_i,
   input  logic                  capture_en_i,
   input  logic                  clear_errors_i,
   input  logic                  fifo_rd_i,
   input  logic [BYTECNT_W-1:0]  reg_bytecnt_i,
   output logic                  trace_ready_o,
   output logic                  la_ready_o,
   output logic [7:0]            fifo_rdata_o,
   output logic                  fifo_empty_o,
   output logic                  fifo_full_o,
   output logic [FIFO_CNT_W-1:0] fifo_count_o,
   output logic                  overflow_o
);

   logic [SAMPLE_W-1:0]   mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [SAMPLE_W-1:0]   sel_data;
   logic [SAMPLE_W-1:0]   head_word;
   logic                  sel_valid;
   logic                  accept;
   logic                  push;
   logic                  pop;
   logic                  lost;

   assign fifo_empty_o = (fifo_count_o == '0);
   assign fifo_full_o  = (fifo_count_o == FIFO_CNT_W'(FIFO_DEPTH));

   // only the selected source sees ready
   assign accept        = capture_en_i && !fifo_full_o;
   assign trace_ready_o = accept && (src_sel_i == SRC_TRACE);
   assign la_ready_o    = accept && (src_sel_i == SRC_LA);

   assign sel_valid = (src_sel_i == SRC_LA) ? la_valid_i : trace_valid_i;
   assign sel_data  = (src_sel_i == SRC_LA) ? la_data_i : trace_data_i;

   assign push = sel_valid && accept;
   assign lost = sel_valid && capture_en_i && fifo_full_o;   // live source, word dropped

   // high byte read retires the head word
   assign pop       = fifo_rd_i && reg_bytecnt_i[0] && !fifo_empty_o;
   assign head_word = mem[rd_ptr];

   always_ff @(posedge clk_usb_buf) begin
      if (push)
         mem[wr_ptr] <= sel_data;
      if (fifo_rd_i) begin
         if (fifo_empty_o)
            fifo_rdata_o <= 8'h00;
         else
            fifo_rdata_o <= reg_bytecnt_i[0] ? head_word[SAMPLE_W-1 -: 8] : head_word[7:0];
      end
   end

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         fifo_count_o <= '0;
         overflow_o   <= 1'b0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   fifo_count_o <= fifo_count_o + 1'b1;
            2'b01:   fifo_count_o <= fifo_count_o - 1'b1;
            default: fifo_count_o <= fifo_count_o;
         endcase
         // clear wins over a loss in the same cycle
         if (clear_errors_i)
            overflow_o <= 1'b0;
         else if (lost)
            overflow_o <= 1'b1;
      end
   end

   // a full FIFO leaves the oldest word untouched
   a_no_push_full: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      (fifo_full_o && !pop) |=> $stable(head_word));

   a_count_bound: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      (fifo_count_o <= FIFO_CNT_W'(FIFO_DEPTH)));

endmodule

/* capture_pkg.sv */
package capture_pkg;

   // one capture word, read back as two bytes
   localparam int SAMPLE_W = 16;

   // shared capture FIFO
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = 5;   // must hold FIFO_DEPTH itself

   // source select, bit 0 of the control register
   localparam logic SRC_TRACE = 1'b0;
   localparam logic SRC_LA    = 1'b1;

   // divider bit for the error flash
   localparam int FLASH_BIT = 3;

endpackage

/* capture_top.sv */
`timescale 1ns/1ps

module capture_top
   import usb_bus_pkg::*, capture_pkg::*;
(
   input  logic                clk_usb_buf,
   input  logic                rst_n_i,
   input  logic [7:0]          usb_addr_i,
   input  logic [7:0]          usb_data_i,
   input  logic                usb_rdn_i,
   input  logic                usb_wrn_i,
   input  logic                usb_cen_i,
   input  logic                trace_valid_i,
   input  logic [SAMPLE_W-1:0] trace_data_i,
   output logic                trace_ready_o,
   input  logic                la_valid_i,
   input  logic [SAMPLE_W-1:0] la_data_i,
   output logic                la_ready_o,
   output logic [7:0]          usb_data_o,
   output logic                usb_data_oe_o,
   output logic                led_armed_o,
   output logic                led_cap_o,
   output logic                led_error_o
);

   logic [4:0]            reg_offset;
   logic [BYTECNT_W-1:0]  reg_bytecnt;
   logic [7:0]            reg_wdata;
   logic                  reg_write;
   logic                  reg_read;
   logic                  fifo_rd;
   logic [7:0]            regs_rdata;
   logic [7:0]            fifo_rdata;
   logic                  src_sel;
   logic                  capture_en;
   logic                  clear_errors;
   logic                  fifo_empty;
   logic                  fifo_full;
   logic [FIFO_CNT_W-1:0] fifo_count;
   logic                  overflow;

   usb_reg_port i_usb_reg_port (
      .clk_usb_buf, .rst_n_i,
      .usb_addr_i, .usb_data_i, .usb_rdn_i, .usb_wrn_i, .usb_cen_i,
      .regs_rdata_i  (regs_rdata),
      .fifo_rdata_i  (fifo_rdata),
      .usb_data_o, .usb_data_oe_o,
      .reg_offset_o  (reg_offset),
      .reg_bytecnt_o (reg_bytecnt),
      .reg_wdata_o   (reg_wdata),
      .reg_write_o   (reg_write),
      .reg_read_o    (reg_read),
      .fifo_rd_o     (fifo_rd)
   );

   capture_ctrl_regs i_capture_ctrl_regs (
      .clk_usb_buf, .rst_n_i,
      .reg_offset_i   (reg_offset),
      .reg_bytecnt_i  (reg_bytecnt),
      .reg_wdata_i    (reg_wdata),
      .reg_write_i    (reg_write),
      .reg_read_i     (reg_read),
      .fifo_empty_i   (fifo_empty),
      .fifo_full_i    (fifo_full),
      .overflow_i     (overflow),
      .fifo_count_i   (fifo_count),
      .regs_rdata_o   (regs_rdata),
      .src_sel_o      (src_sel),
      .capture_en_o   (capture_en),
      .clear_errors_o (clear_errors)
   );

   capture_fifo i_capture_fifo (
      .clk_usb_buf, .rst_n_i,
      .trace_valid_i, .trace_data_i, .la_valid_i, .la_data_i,
      .src_sel_i      (src_sel),
      .capture_en_i   (capture_en),
      .clear_errors_i (clear_errors),
      .fifo_rd_i      (fifo_rd),
      .reg_bytecnt_i  (reg_bytecnt),
      .trace_ready_o, .la_ready_o,
      .fifo_rdata_o   (fifo_rdata),
      .fifo_empty_o   (fifo_empty),
      .fifo_full_o    (fifo_full),
      .fifo_count_o   (fifo_count),
      .overflow_o     (overflow)
   );

   status_leds i_status_leds (
      .clk_usb_buf, .rst_n_i,
      .capture_en_i (capture_en),
      .fifo_empty_i (fifo_empty),
      .overflow_i   (overflow),
      .led_armed_o, .led_cap_o, .led_error_o
   );

endmodule

/* run_sim.sh */
#!/bin/sh
# compile and run the capture testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_capture_top \
   -f build.f -o sim_capture
out=$(./obj_dir/sim_capture) || true
echo "$out"
if echo "$out" | grep -qx "RESULT: PASS"; then
   exit 0
fi
exit 1

/* status_leds.sv */
`timescale 1ns/1ps

module status_leds
   import capture_pkg::*;
(
   input  logic clk_usb_buf,
   input  logic rst_n_i,
   input  logic capture_en_i,
   input  logic fifo_empty_i,
   input  logic overflow_i,
   output logic led_armed_o,
   output logic led_cap_o,
   output logic led_error_o
);

   logic [FLASH_BIT:0] div_q;   // free running, only the top bit is seen

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         div_q       <= '0;
         led_armed_o <= 1'b0;
         led_cap_o   <= 1'b0;
         led_error_o <= 1'b0;
      end else begin
         div_q       <= div_q + 1'b1;
         led_armed_o <= capture_en_i;
         led_cap_o   <= !fifo_empty_i;   // data waiting
         // flash while overflow is pending
         led_error_o <= overflow_i && div_q[FLASH_BIT];
      end
   end

endmodule

/* tb_capture_top.sv */
`timescale 1ns/1ps

module tb_capture_top
   import usb_bus_pkg::*, capture_pkg::*;
();

   localparam int WORD_CYCLES     = 12;    // one two-byte FIFO read burst
   localparam int ACCESS_CYCLES   = 8;     // one single-byte register access
   localparam int TEST_CYCLES     = 3 * FIFO_DEPTH * WORD_CYCLES + 20 * ACCESS_CYCLES + 200;
   localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

   localparam logic [7:0] ADDR_CTRL      = {CTRL_BLOCK, OFS_CTRL};
   localparam logic [7:0] ADDR_STATUS    = {CTRL_BLOCK, OFS_STATUS};
   localparam logic [7:0] ADDR_CLEAR     = {CTRL_BLOCK, OFS_CLEAR};
   localparam logic [7:0] ADDR_WORDCOUNT = {CTRL_BLOCK, OFS_WORDCOUNT};
   localparam logic [7:0] ADDR_UNMAPPED  = 8'h40;

   logic                clk_usb_buf;
   logic                rst_n_i;
   logic [7:0]          usb_addr_i;
   logic [7:0]          usb_data_i;
   logic                usb_rdn_i;
   logic                usb_wrn_i;
   logic                usb_cen_i;
   logic                trace_valid_i;
   logic [SAMPLE_W-1:0] trace_data_i;
   logic                trace_ready_o;
   logic                la_valid_i;
   logic [SAMPLE_W-1:0] la_data_i;
   logic                la_ready_o;
   logic [7:0]          usb_data_o;
   logic                usb_data_oe_o;
   logic                led_armed_o;
   logic                led_cap_o;
   logic                led_error_o;

   logic [15:0] model_q[$];   // words the FIFO accepted, in order
   logic [15:0] sent_q[$];    // every valid trace word, accepted or not
   logic [31:0] rng_state;
   int          checks;
   int          check_errors;
   int          prop_errors;
   logic        la_only;
   logic        capture_off;
   logic        error_quiet;
   logic        reading;      // bus read burst in progress

   capture_top i_dut (.*);

   initial begin
      clk_usb_buf = 1'b0;
      forever #4 clk_usb_buf = ~clk_usb_buf;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      checks++;
      assert (got === exp) else begin
         check_errors++;
         $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   // one read strobe inside an open chip select
   task automatic read_strobe(output logic [7:0] data);
      usb_rdn_i = 1'b0;
      repeat (3) @(posedge clk_usb_buf);   // valid two cycles after the first sample
      @(negedge clk_usb_buf);
      check_value("usb_data_oe_o", 16'(usb_data_oe_o), 16'h1);
      data      = usb_data_o;
      usb_rdn_i = 1'b1;
      repeat (2) @(negedge clk_usb_buf);
   endtask

   task automatic bus_read(input logic [7:0] addr, input int nbytes, output logic [15:0] data);
      logic [7:0] b;
      data       = '0;
      reading    = 1'b1;
      usb_cen_i  = 1'b0;
      usb_addr_i = addr;
      for (int i = 0; i < nbytes; i++) begin
         read_strobe(b);
         data[8*i +: 8] = b;   // low byte first
      end
      usb_cen_i = 1'b1;
      repeat (2) @(negedge clk_usb_buf);
      reading = 1'b0;
   endtask

   task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
      usb_cen_i  = 1'b0;
      usb_addr_i = addr;
      usb_data_i = data;
      usb_wrn_i  = 1'b0;
      repeat (2) @(posedge clk_usb_buf);
      @(negedge clk_usb_buf);
      check_value("usb_data_oe_o", 16'(usb_data_oe_o), 16'h0);
      usb_wrn_i = 1'b1;
      @(negedge clk_usb_buf);
      usb_cen_i = 1'b1;
      repeat (3) @(negedge clk_usb_buf);   // byte counter back to 0
   endtask

   task automatic drive_samples(input int cycles, input logic on_trace, input logic on_la,
                                input logic every_cycle);
      for (int i = 0; i < cycles; i++) begin
         rng_state     = xorshift32(rng_state);
         trace_valid_i = on_trace && (every_cycle || rng_state[0]);
         la_valid_i    = on_la && (every_cycle || rng_state[1]);
         trace_data_i  = rng_state[31:16];
         la_data_i     = rng_state[23:8];
         if (trace_valid_i)
            sent_q.push_back(trace_data_i);
         // ready settles after the rising edge, so it holds here
         if (trace_valid_i && trace_ready_o)
            model_q.push_back(trace_data_i);
         if (la_valid_i && la_ready_o)
            model_q.push_back(la_data_i);
         @(negedge clk_usb_buf);
      end
      trace_valid_i = 1'b0;
      la_valid_i    = 1'b0;
   endtask

   task automatic read_and_compare(input string name);
      logic [15:0] w;
      while (model_q.size() > 0) begin
         bus_read(FIFO_DATA_ADDR, 2, w);
         check_value(name, w, model_q.pop_front());
      end
   endtask

   task automatic watch_error_led();
      logic seen_hi;
      logic seen_lo;
      seen_hi = 1'b0;
      seen_lo = 1'b0;
      repeat (4 << FLASH_BIT) begin
         @(negedge clk_usb_buf);
         if (led_error_o)
            seen_hi = 1'b1;
         else
            seen_lo = 1'b1;
      end
      checks++;
      assert (seen_hi && seen_lo) else begin
         check_errors++;
         $display("led_error_o did not flash while the overflow flag was set");
      end
   endtask

   a_oe_on_read: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      usb_data_oe_o |-> reading)
      else begin
         prop_errors++;
         $display("error: usb_data_oe_o = 0x%h outside a bus read", usb_data_oe_o);
      end

   a_one_ready: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      !(trace_ready_o && la_ready_o))
      else begin
         prop_errors++;
         $display("error: trace_ready_o = 0x%h with la_ready_o = 0x%h", trace_ready_o,
                  la_ready_o);
      end

   a_la_only: assert property (@(posedge clk_usb_buf) la_only |-> !trace_ready_o)
      else begin
         prop_errors++;
         $display("error: trace_ready_o = 0x%h with LA selected", trace_ready_o);
      end

   a_capture_off: assert property (@(posedge clk_usb_buf)
      capture_off |-> (!trace_ready_o && !la_ready_o))
      else begin
         prop_errors++;
         $display("error: trace_ready_o = 0x%h, la_ready_o = 0x%h while disabled",
                  trace_ready_o, la_ready_o);
      end

   a_error_quiet: assert property (@(posedge clk_usb_buf) error_quiet |-> !led_error_o)
      else begin
         prop_errors++;
         $display("error: led_error_o = 0x%h after clear", led_error_o);
      end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_usb_buf);
      $display("watchdog expired after %0d cycles, test did not finish", WATCHDOG_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      logic [15:0] rd;
      rst_n_i       = 1'b0;
      usb_addr_i    = 8'h00;
      usb_data_i    = 8'h00;
      usb_rdn_i     = 1'b1;
      usb_wrn_i     = 1'b1;
      usb_cen_i     = 1'b1;
      trace_valid_i = 1'b0;
      trace_data_i  = '0;
      la_valid_i    = 1'b0;
      la_data_i     = '0;
      la_only       = 1'b0;
      capture_off   = 1'b0;
      error_quiet   = 1'b0;
      reading       = 1'b0;
      checks        = 0;
      check_errors  = 0;
      prop_errors   = 0;
      rng_state     = 32'h2d1e_f48c;
      repeat (2) @(posedge clk_usb_buf);
      @(negedge clk_usb_buf);
      rst_n_i = 1'b1;
      @(negedge clk_usb_buf);

      // reset state
      check_value("trace_ready_o", 16'(trace_ready_o), 16'h0);
      check_value("la_ready_o", 16'(la_ready_o), 16'h0);
      check_value("usb_data_oe_o", 16'(usb_data_oe_o), 16'h0);
      check_value("leds", 16'({led_armed_o, led_cap_o, led_error_o}), 16'h0);
      bus_read(ADDR_STATUS, 1, rd);
      check_value("status", rd, 16'h0001);

      // control register readback
      bus_write(ADDR_CTRL, 8'h01);
      bus_read(ADDR_CTRL, 1, rd);
      check_value("ctrl", rd, 16'h0001);
      bus_write(ADDR_CTRL, 8'h02);   // trace source, capture on
      bus_read(ADDR_CTRL, 1, rd);
      check_value("ctrl", rd, 16'h0002);
      check_value("led_armed_o", 16'(led_armed_o), 16'h1);
      bus_read(ADDR_UNMAPPED, 1, rd);
      check_value("unmapped", rd, 16'h0000);

      // trace capture
      drive_samples(FIFO_DEPTH, 1'b1, 1'b0, 1'b0);
      bus_read(ADDR_WORDCOUNT, 2, rd);
      check_value("wordcount", rd, 16'(model_q.size()));
      check_value("led_cap_o", 16'(led_cap_o), 16'(model_q.size() != 0));
      read_and_compare("trace word");
      bus_read(ADDR_STATUS, 1, rd);
      check_value("status", rd, 16'h0001);

      // LA selected, trace must stay stalled out
      bus_write(ADDR_CTRL, 8'h03);
      la_only = 1'b1;
      drive_samples(FIFO_DEPTH, 1'b1, 1'b1, 1'b0);
      la_only = 1'b0;
      read_and_compare("la word");

      bus_write(ADDR_CTRL, 8'h01);   // capture off
      capture_off = 1'b1;
      drive_samples(12, 1'b1, 1'b1, 1'b1);
      capture_off = 1'b0;
      check_value("accepted words", 16'(model_q.size()), 16'h0);

      // overflow with a live trace source
      bus_write(ADDR_CTRL, 8'h02);
      sent_q.delete();
      drive_samples(FIFO_DEPTH + 6, 1'b1, 1'b0, 1'b1);
      bus_read(ADDR_STATUS, 1, rd);
      check_value("status", rd, 16'h0006);
      check_value("accepted words", 16'(model_q.size()), 16'(FIFO_DEPTH));
      watch_error_led();
      for (int i = 0; i < FIFO_DEPTH; i++) begin
         bus_read(FIFO_DATA_ADDR, 2, rd);
         check_value("overflow word", rd, sent_q[i]);
      end
      model_q.delete();
      bus_write(ADDR_CLEAR, 8'h01);
      bus_read(ADDR_STATUS, 1, rd);
      check_value("status", rd, 16'h0001);
      error_quiet = 1'b1;
      repeat (40) @(negedge clk_usb_buf);
      error_quiet = 1'b0;
      bus_write(ADDR_CTRL, 8'h00);

      $display("checks %0d, check errors %0d, assertion errors %0d", checks, check_errors,
               prop_errors);
      if (check_errors == 0 && prop_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* usb_bus_pkg.sv */
package usb_bus_pkg;

   // byte index inside one two-byte word
   localparam int BYTECNT_W = 1;

   // bus address, read flat for the FIFO port and split for register blocks
   typedef union packed {
      logic [7:0] flat;
      struct packed {
         logic [2:0] block;
         logic [4:0] offset;
      } field;
   } reg_addr_u;

   localparam logic [7:0] FIFO_DATA_ADDR = 8'h03;   // FIFO data port, flat view
   localparam logic [2:0] CTRL_BLOCK     = 3'd1;    // capture register block

   // register offsets inside CTRL_BLOCK
   localparam logic [4:0] OFS_CTRL      = 5'd0;
   localparam logic [4:0] OFS_STATUS    = 5'd1;     // read only
   localparam logic [4:0] OFS_CLEAR     = 5'd2;     // write only
   localparam logic [4:0] OFS_WORDCOUNT = 5'd4;     // low byte first

   // control bits
   localparam int CTRL_SRC_BIT = 0;
   localparam int CTRL_EN_BIT  = 1;

   // status bits
   localparam int STAT_EMPTY_BIT = 0;
   localparam int STAT_FULL_BIT  = 1;
   localparam int STAT_OVF_BIT   = 2;   // sticky until cleared

   localparam int CLEAR_ERR_BIT = 0;

endpackage

/* usb_reg_port.sv */
`timescale 1ns/1ps

module usb_reg_port
   import usb_bus_pkg::*;
(
   input  logic                 clk_usb_buf,
   input  logic                 rst_n_i,
   input  logic [7:0]           usb_addr_i,
   input  logic [7:0]           usb_data_i,
   input  logic                 usb_rdn_i,
   input  logic                 usb_wrn_i,
   input  logic                 usb_cen_i,
   input  logic [7:0]           regs_rdata_i,
   input  logic [7:0]           fifo_rdata_i,
   output logic [7:0]           usb_data_o,
   output logic                 usb_data_oe_o,
   output logic [4:0]           reg_offset_o,
   output logic [BYTECNT_W-1:0] reg_bytecnt_o,
   output logic [7:0]           reg_wdata_o,
   output logic                 reg_write_o,
   output logic                 reg_read_o,
   output logic                 fifo_rd_o
);

   logic                 rdn_q;
   logic                 rdn_qq;
   logic                 wrn_q;
   logic                 wrn_qq;
   logic                 cen_q;
   reg_addr_u            addr_q;
   logic [7:0]           data_q;
   logic                 rd_strobe;
   logic                 wr_strobe;
   logic                 ctrl_hit;
   logic                 fifo_hit;
   logic [BYTECNT_W-1:0] bytecnt_q;
   logic                 rd_pend;
   logic                 rsp_vld;
   logic                 rsp_ctrl;
   logic                 rsp_fifo;
   logic [7:0]           rsp_byte;
   logic [7:0]           data_hold;

   // falling edge of a strobe inside an active chip select
   assign rd_strobe = !rdn_q && rdn_qq && !cen_q;
   assign wr_strobe = !wrn_q && wrn_qq && !cen_q;

   assign ctrl_hit = (addr_q.field.block == CTRL_BLOCK);
   assign fifo_hit = (addr_q.flat == FIFO_DATA_ADDR);

   assign usb_data_oe_o = !rdn_q && !cen_q;

   // unmapped reads fall through to zero
   assign rsp_byte   = rsp_fifo ? fifo_rdata_i : (rsp_ctrl ? regs_rdata_i : 8'h00);
   assign usb_data_o = rsp_vld ? rsp_byte : data_hold;

   always_ff @(posedge clk_usb_buf) begin
      addr_q <= usb_addr_i;
      data_q <= usb_data_i;
      if (rd_strobe || wr_strobe) begin
         reg_offset_o  <= addr_q.field.offset;
         reg_bytecnt_o <= bytecnt_q;   // index before this strobe
      end
      if (wr_strobe)
         reg_wdata_o <= data_q;
      if (rsp_vld)
         data_hold <= rsp_byte;   // keep driving until rdn rises
   end

   always_ff @(posedge clk_usb_buf) begin
      if (!rst_n_i) begin
         rdn_q       <= 1'b1;
         rdn_qq      <= 1'b1;
         wrn_q       <= 1'b1;
         wrn_qq      <= 1'b1;
         cen_q       <= 1'b1;
         bytecnt_q   <= '0;
         reg_write_o <= 1'b0;
         reg_read_o  <= 1'b0;
         fifo_rd_o   <= 1'b0;
         rd_pend     <= 1'b0;
         rsp_vld     <= 1'b0;
         rsp_ctrl    <= 1'b0;
         rsp_fifo    <= 1'b0;
      end else begin
         rdn_q  <= usb_rdn_i;
         rdn_qq <= rdn_q;
         wrn_q  <= usb_wrn_i;
         wrn_qq <= wrn_q;
         cen_q  <= usb_cen_i;
         if (cen_q)
            bytecnt_q <= '0;
         else if (rd_strobe || wr_strobe)
            bytecnt_q <= bytecnt_q + 1'b1;
         reg_write_o <= wr_strobe && ctrl_hit;
         reg_read_o  <= rd_strobe && ctrl_hit;
         fifo_rd_o   <= rd_strobe && fifo_hit;
         rd_pend     <= rd_strobe;
         rsp_vld     <= rd_pend;   // read data arrives one cycle after the pulse
         rsp_ctrl    <= reg_read_o;
         rsp_fifo    <= fifo_rd_o;
      end
   end

   // bus only driven inside a chip-select burst
   a_oe_needs_cen: assert property (@(posedge clk_usb_buf) disable iff (!rst_n_i)
      usb_cen_i |-> !usb_data_oe_o);

endmodule
